/* vlog.f */
+incdir+.
heapPkg.sv
arrayAllocator.sv
arrayStore.sv
arraySearch.sv
heapController.sv
heapMemory.sv
tbClock.sv
heapMemoryTb.sv

/* heapMemoryTb.sv */
//--------------------
// Array heap testbench
// Table of commands and expected responses, random response stalls, cycle watchdog
//--------------------
`timescale 1ns/1ps
`include "heap_settings.svh"

module heapMemoryTb;

  logic           clock;
  logic           resetN;
  logic           reqValid;
  logic           reqReady;
  heapPkg::opT    reqOp;
  heapPkg::arrayT reqArray;
  heapPkg::indexT reqIndex;
  heapPkg::dataT  reqData;
  logic           respValid;
  logic           respReady;
  heapPkg::dataT  respData;
  heapPkg::errorT respError;

  //--------------------
  // Command table
  string          rowName [$];
  heapPkg::opT    rowOp [$];
  heapPkg::arrayT rowArray [$];
  heapPkg::indexT rowIndex [$];
  heapPkg::dataT  rowData [$];
  heapPkg::dataT  rowExpData [$];
  heapPkg::errorT rowExpError [$];

  int cycles       = 0;
  int timeoutLimit = 0;                                       // Set once the table is built
  int passCount    = 0;
  int failCount    = 0;
  bit rowFailed;

  tbClock tbClock_inst (.clock(clock), .resetN(resetN));

  heapMemory heapMemory_inst (.*);

  task automatic addRow(input string name, input heapPkg::opT op, input int arr,
                        input int idx, input int data, input int expData,
                        input heapPkg::errorT expError);
    rowName.push_back(name);
    rowOp.push_back(op);
    rowArray.push_back(heapPkg::arrayT'(arr));
    rowIndex.push_back(heapPkg::indexT'(idx));
    rowData.push_back(heapPkg::dataT'(data));
    rowExpData.push_back(heapPkg::dataT'(expData));
    rowExpError.push_back(expError);
  endtask

  task automatic buildTable();
    addRow("read before alloc", heapPkg::opRead, 0, 0, 0, 0, heapPkg::errNotAllocated);
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      addRow($sformatf("alloc %0d", i), heapPkg::opAlloc, 0, 0, 0, i, heapPkg::errNone);
    end
    addRow("alloc exhausted", heapPkg::opAlloc, 0, 0, 0, 0, heapPkg::errOutOfMemory);
    // Element access on array 0
    addRow("write 10", heapPkg::opWrite, 0, 0, 10, 10, heapPkg::errNone);
    addRow("write 20", heapPkg::opWrite, 0, 1, 20, 20, heapPkg::errNone);
    addRow("write 30", heapPkg::opWrite, 0, 2, 30, 30, heapPkg::errNone);
    addRow("size after writes", heapPkg::opSize, 0, 0, 0, 3, heapPkg::errNone);
    addRow("read index 1", heapPkg::opRead, 0, 1, 0, 20, heapPkg::errNone);
    addRow("read out of bounds", heapPkg::opRead, 0, 5, 0, 0, heapPkg::errBounds);
    // Searches over 10, 20, 30
    addRow("index of 30", heapPkg::opIndex, 0, 0, 30, 3, heapPkg::errNone);
    addRow("index of 20", heapPkg::opIndex, 0, 0, 20, 2, heapPkg::errNone);
    addRow("index of 10", heapPkg::opIndex, 0, 0, 10, 1, heapPkg::errNone);
    addRow("index of 15", heapPkg::opIndex, 0, 0, 15, 0, heapPkg::errNone);
    addRow("less than 35", heapPkg::opLess, 0, 0, 35, 3, heapPkg::errNone);
    addRow("less than 25", heapPkg::opLess, 0, 0, 25, 2, heapPkg::errNone);
    addRow("less than 15", heapPkg::opLess, 0, 0, 15, 1, heapPkg::errNone);
    addRow("less than 5", heapPkg::opLess, 0, 0, 5, 0, heapPkg::errNone);
    addRow("greater than 35", heapPkg::opGreater, 0, 0, 35, 0, heapPkg::errNone);
    addRow("greater than 25", heapPkg::opGreater, 0, 0, 25, 1, heapPkg::errNone);
    addRow("greater than 15", heapPkg::opGreater, 0, 0, 15, 2, heapPkg::errNone);
    addRow("greater than 5", heapPkg::opGreater, 0, 0, 5, 3, heapPkg::errNone);
    addRow("write past end", heapPkg::opWrite, 0, 6, 70, 70, heapPkg::errNone);
    addRow("size after extend", heapPkg::opSize, 0, 0, 0, 7, heapPkg::errNone);
    // Stack use of array 3
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      addRow($sformatf("push %0d", i), heapPkg::opPush, 3, 0, 100 + 7 * i, 0, heapPkg::errNone);
    end
    addRow("push full", heapPkg::opPush, 3, 0, 999, 0, heapPkg::errFull);
    for (int i = `HEAP_ARRAY_LENGTH - 1; i >= 0; i--) begin
      addRow($sformatf("pop %0d", i), heapPkg::opPop, 3, 0, 0, 100 + 7 * i, heapPkg::errNone);
    end
    addRow("pop empty", heapPkg::opPop, 3, 0, 0, 0, heapPkg::errEmpty);
    // Free and reuse, last freed comes back first
    addRow("free 1", heapPkg::opFree, 1, 0, 0, 0, heapPkg::errNone);
    addRow("free 2", heapPkg::opFree, 2, 0, 0, 0, heapPkg::errNone);
    addRow("read freed", heapPkg::opRead, 1, 0, 0, 0, heapPkg::errFreed);
    addRow("free twice", heapPkg::opFree, 1, 0, 0, 0, heapPkg::errFreed);
    addRow("realloc 2", heapPkg::opAlloc, 0, 0, 0, 2, heapPkg::errNone);
    addRow("realloc 1", heapPkg::opAlloc, 0, 0, 0, 1, heapPkg::errNone);
  endtask

  //--------------------
  // Checks
  task automatic checkValue(input string testName, input string field,
                            input int expected, input int actual);
    assert (expected == actual) else begin
      $display("Error %s: %s expected %0d, actual %0d", testName, field, expected, actual);
      rowFailed = 1'b1;
    end
  endtask

  task automatic checkError(input string testName, input heapPkg::errorT expected,
                            input heapPkg::errorT actual);
    assert (expected == actual) else begin
      $display("Error %s: respError expected %s, actual %s", testName, expected.name(),
               actual.name());
      rowFailed = 1'b1;
    end
  endtask

  task automatic reportRow(input string testName);
    if (rowFailed) begin
      failCount++;
      $display("fail  %s", testName);
    end else begin
      passCount++;
      $display("pass  %s", testName);
    end
  endtask

  task automatic runRow(input int r);
    int             latency;
    int             stall;
    bit             isSearch;
    heapPkg::dataT  heldData;
    heapPkg::errorT heldError;
    rowFailed = 1'b0;
    isSearch  = rowOp[r] inside {heapPkg::opIndex, heapPkg::opLess, heapPkg::opGreater};
    reqValid  = 1'b1;
    reqOp     = rowOp[r];
    reqArray  = rowArray[r];
    reqIndex  = rowIndex[r];
    reqData   = rowData[r];
    while (!reqReady) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);                                         // Request taken here
    #1;
    reqValid = 1'b0;
    latency  = 0;
    while (!respValid) begin
      @(posedge clock);
      #1;
      latency++;
    end
    if (!isSearch) begin
      checkValue(rowName[r], "latency", 2, latency);          // Fixed two-edge latency
    end
    heldData  = respData;
    heldError = respError;
    stall     = $urandom % 4;
    repeat (stall) begin
      assert (!reqReady) else begin
        $display("Error %s: reqReady went high while a response was waiting", rowName[r]);
        rowFailed = 1'b1;
      end
      @(posedge clock);
      #1;
      assert (respValid && respData == heldData && respError == heldError) else begin
        $display("Error %s: the response changed before it was taken", rowName[r]);
        rowFailed = 1'b1;
      end
    end
    assert (!reqReady) else begin
      $display("Error %s: reqReady went high while a response was waiting", rowName[r]);
      rowFailed = 1'b1;
    end
    checkValue(rowName[r], "respData", rowExpData[r], respData);
    checkError(rowName[r], rowExpError[r], respError);
    respReady = 1'b1;
    @(posedge clock);                                         // Response taken here
    #1;
    respReady = 1'b0;
    reportRow(rowName[r]);
  endtask

  //--------------------
  // Watchdog
  always @(posedge clock) begin
    cycles++;
    if (timeoutLimit > 0 && cycles >= timeoutLimit) begin
      $display("Error: the DUT stopped responding, no progress within %0d cycles",
               timeoutLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  //--------------------
  // Main sequence
  initial begin
    reqValid  = 1'b0;
    reqOp     = heapPkg::opAlloc;
    reqArray  = '0;
    reqIndex  = '0;
    reqData   = '0;
    respReady = 1'b0;
    void'($urandom(32'h7b0));
    buildTable();
    timeoutLimit = rowOp.size() * (`HEAP_ARRAY_LENGTH + 10);
    while (resetN !== 1'b1) begin
      @(posedge clock);
    end
    #1;
    rowFailed = 1'b0;                                         // Idle state after reset
    checkValue("reset state", "reqReady", 1, reqReady);
    checkValue("reset state", "respValid", 0, respValid);
    checkValue("reset state", "respData", 0, respData);
    reportRow("reset state");
    for (int r = 0; r < rowOp.size(); r++) begin
      runRow(r);
    end
    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tbClock.sv */
//--------------------
// Testbench clock and reset
// 10 ns clock, active-low reset held for 4 cycles
//--------------------
`timescale 1ns/1ps

module tbClock (
  output logic clock,
  output logic resetN
);

  localparam int ResetCycles = 4;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                                // 10 ns period
  end

  initial begin
    resetN = 1'b0;
    repeat (ResetCycles) @(posedge clock);
    #1 resetN = 1'b1;                                         // Release off the edge
  end

endmodule

/* heapMemory.sv */
//--------------------
// Array heap top
// Connects controller, allocator, store and search to the host ports
//--------------------
`timescale 1ns/1ps

module heapMemory (
  input  logic           clock,
  input  logic           resetN,
  input  logic           reqValid,
  output logic           reqReady,
  input  heapPkg::opT    reqOp,
  input  heapPkg::arrayT reqArray,
  input  heapPkg::indexT reqIndex,
  input  heapPkg::dataT  reqData,
  output logic           respValid,
  input  logic           respReady,
  output heapPkg::dataT  respData,
  output heapPkg::errorT respError
);

  logic           allocStart, allocOk, freeStart, isAllocated, wasFreed;
  heapPkg::arrayT allocArray, freeArray, queryArray;
  logic           elemWrite, sizeWrite;
  heapPkg::arrayT cmdArray, scanArray;
  heapPkg::indexT cmdIndex, scanIndex;
  heapPkg::dataT  cmdData, cmdReadData, scanData, scanKey;
  heapPkg::sizeT  cmdSize, cmdReadSize, scanSize, scanResult;
  logic           scanStart, scanDone;
  heapPkg::scanT  scanKind;

  heapController heapController_inst (.*);                    // Command FSM

  arrayAllocator arrayAllocator_inst (.*);

  arrayStore arrayStore_inst (.*);

  arraySearch arraySearch_inst (.*);                          // Scan shares the array from cmdArray

endmodule

/* heapController.sv */
//--------------------
// Heap controller
// Takes one host command at a time, checks it, runs it and holds the response
//--------------------
`timescale 1ns/1ps
`include "heap_settings.svh"

module heapController (
  input  logic           clock,
  input  logic           resetN,
  // Host side
  input  logic           reqValid,
  output logic           reqReady,
  input  heapPkg::opT    reqOp,
  input  heapPkg::arrayT reqArray,
  input  heapPkg::indexT reqIndex,
  input  heapPkg::dataT  reqData,
  output logic           respValid,
  input  logic           respReady,
  output heapPkg::dataT  respData,
  output heapPkg::errorT respError,
  // Allocator side
  output logic           allocStart,
  input  logic           allocOk,
  input  heapPkg::arrayT allocArray,
  output logic           freeStart,
  output heapPkg::arrayT freeArray,
  output heapPkg::arrayT queryArray,
  input  logic           isAllocated,
  input  logic           wasFreed,
  // Store side
  output logic           elemWrite,
  output logic           sizeWrite,
  output heapPkg::arrayT cmdArray,
  output heapPkg::indexT cmdIndex,
  output heapPkg::dataT  cmdData,
  output heapPkg::sizeT  cmdSize,
  input  heapPkg::dataT  cmdReadData,
  input  heapPkg::sizeT  cmdReadSize,
  // Search side
  output logic           scanStart,
  output heapPkg::scanT  scanKind,
  output heapPkg::dataT  scanKey,
  output heapPkg::sizeT  scanSize,
  input  logic           scanDone,
  input  heapPkg::sizeT  scanResult
);

  typedef enum logic [2:0] {
    stIdle,
    stLookup,
    stExecute,
    stScanning,
    stRespond
  } stateT;

  stateT          state;
  heapPkg::opT    opReg;
  heapPkg::arrayT arrayReg;
  heapPkg::indexT indexReg;
  heapPkg::dataT  dataReg;
  heapPkg::dataT  respDataReg;
  heapPkg::errorT respErrorReg;
  logic           respFromAlloc;                              // Answer comes from the allocator
  heapPkg::dataT  execData;
  heapPkg::errorT execError;
  heapPkg::sizeT  indexAsSize;

  assign indexAsSize = heapPkg::sizeT'(indexReg);

  //--------------------
  // Request capture
  always_ff @(posedge clock) begin
    if (state == stIdle && reqValid) begin
      opReg    <= reqOp;
      arrayReg <= reqArray;
      indexReg <= reqIndex;
      dataReg  <= reqData;
    end
  end

  // Store addressing
  always_comb begin
    cmdArray = arrayReg;
    cmdIndex = indexReg;
    case (state)
      stIdle: begin
        cmdArray = reqArray;                                  // Size read starts at acceptance
        cmdIndex = reqIndex;
      end
      stLookup: begin
        if (opReg == heapPkg::opPop) begin
          cmdIndex = heapPkg::indexT'(cmdReadSize - 1'b1);    // Top element
        end
      end
      stExecute: begin
        if (opReg == heapPkg::opPush) begin
          cmdIndex = heapPkg::indexT'(cmdReadSize);           // First free slot
        end
      end
      default: ;
    endcase
  end

  assign queryArray = arrayReg;
  assign freeArray  = arrayReg;
  assign cmdData    = dataReg;
  assign scanKey    = dataReg;
  assign scanSize   = cmdReadSize;

  always_comb begin
    case (opReg)
      heapPkg::opLess:    scanKind = heapPkg::scanLess;
      heapPkg::opGreater: scanKind = heapPkg::scanGreater;
      default:            scanKind = heapPkg::scanIndex;
    endcase
  end

  //--------------------
  // Error rules and the single action
  always_comb begin
    elemWrite  = 1'b0;
    sizeWrite  = 1'b0;
    cmdSize    = cmdReadSize;
    allocStart = 1'b0;
    freeStart  = 1'b0;
    scanStart  = 1'b0;
    execData   = '0;
    execError  = heapPkg::errNone;
    if (state == stExecute) begin
      if (opReg != heapPkg::opAlloc && !isAllocated) begin
        execError = wasFreed ? heapPkg::errFreed : heapPkg::errNotAllocated;
      end else begin
        case (opReg)
          heapPkg::opAlloc: allocStart = 1'b1;
          heapPkg::opFree: begin
            freeStart = 1'b1;
            sizeWrite = 1'b1;                                 // Reuse starts empty
            cmdSize   = '0;
          end
          heapPkg::opWrite: begin
            elemWrite = 1'b1;
            execData  = dataReg;
            if (indexAsSize >= cmdReadSize) begin             // Past the end extends
              sizeWrite = 1'b1;
              cmdSize   = indexAsSize + heapPkg::sizeT'(1);
            end
          end
          heapPkg::opRead: begin
            if (indexAsSize >= cmdReadSize) begin
              execError = heapPkg::errBounds;
            end else begin
              execData = cmdReadData;
            end
          end
          heapPkg::opSize: execData = heapPkg::dataT'(cmdReadSize);
          heapPkg::opPush: begin
            if (cmdReadSize == `HEAP_ARRAY_LENGTH) begin
              execError = heapPkg::errFull;
            end else begin
              elemWrite = 1'b1;
              sizeWrite = 1'b1;
              cmdSize   = cmdReadSize + heapPkg::sizeT'(1);
            end
          end
          heapPkg::opPop: begin
            if (cmdReadSize == '0) begin
              execError = heapPkg::errEmpty;
            end else begin
              sizeWrite = 1'b1;
              cmdSize   = cmdReadSize - heapPkg::sizeT'(1);
              execData  = cmdReadData;
            end
          end
          heapPkg::opIndex, heapPkg::opLess, heapPkg::opGreater: scanStart = 1'b1;
          default: ;                                          // Unknown op does nothing
        endcase
      end
    end
  end

  //--------------------
  // Command sequencing
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state         <= stIdle;
      respDataReg   <= '0;
      respErrorReg  <= heapPkg::errNone;
      respFromAlloc <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (reqValid) begin
            state <= stLookup;
          end
        end
        stLookup: state <= stExecute;
        stExecute: begin
          respDataReg   <= execData;
          respErrorReg  <= execError;
          respFromAlloc <= (opReg == heapPkg::opAlloc);
          state         <= scanStart ? stScanning : stRespond;
        end
        stScanning: begin
          if (scanDone) begin
            respDataReg <= heapPkg::dataT'(scanResult);
            state       <= stRespond;
          end
        end
        stRespond: begin
          if (respReady) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Response port
  assign reqReady  = (state == stIdle);
  assign respValid = (state == stRespond);
  assign respData  = respFromAlloc ? (allocOk ? heapPkg::dataT'(allocArray) : '0) : respDataReg;
  assign respError = (respFromAlloc && !allocOk) ? heapPkg::errOutOfMemory : respErrorReg;

endmodule

/* arraySearch.sv */
//--------------------
// Array search
// Walks the live elements of one array and counts or locates matches
//--------------------
`timescale 1ns/1ps

module arraySearch (
  input  logic           clock,
  input  logic           resetN,
  input  logic           scanStart,
  input  heapPkg::scanT  scanKind,
  input  heapPkg::dataT  scanKey,
  input  heapPkg::sizeT  scanSize,
  input  heapPkg::arrayT cmdArray,
  output heapPkg::arrayT scanArray,
  output heapPkg::indexT scanIndex,
  input  heapPkg::dataT  scanData,
  output logic           scanDone,
  output heapPkg::sizeT  scanResult
);

  heapPkg::scanT  kind;
  heapPkg::dataT  key;
  heapPkg::indexT lastIndex;                                  // Final position to read
  heapPkg::indexT dataIndex;                                  // Position of scanData
  heapPkg::sizeT  count;
  heapPkg::sizeT  nextCount;
  logic           issuing;                                    // Addresses still going out
  logic           dataValid;
  logic           lastData;
  logic           emptyDone;                                  // Zero-size finish
  logic           hit;

  //--------------------
  // Latch the job
  always_ff @(posedge clock) begin
    if (scanStart) begin
      kind      <= scanKind;
      key       <= scanKey;
      scanArray <= cmdArray;
      lastIndex <= heapPkg::indexT'(scanSize - 1'b1);
    end
    dataIndex <= scanIndex;                                   // Tracks the read latency
  end

  // Compare the returned element
  always_comb begin
    case (kind)
      heapPkg::scanLess:    hit = scanData < key;
      heapPkg::scanGreater: hit = scanData > key;
      default:              hit = scanData == key;
    endcase
    nextCount = count;
    if (dataValid && hit) begin
      if (kind == heapPkg::scanIndex) begin
        nextCount = heapPkg::sizeT'(dataIndex) + heapPkg::sizeT'(1);  // Later match wins
      end else begin
        nextCount = count + heapPkg::sizeT'(1);
      end
    end
  end

  //--------------------
  // Address walk and accumulation
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      issuing   <= 1'b0;
      dataValid <= 1'b0;
      lastData  <= 1'b0;
      emptyDone <= 1'b0;
      scanIndex <= '0;
      count     <= '0;
    end else begin
      dataValid <= issuing;
      lastData  <= issuing && (scanIndex == lastIndex);
      emptyDone <= scanStart && (scanSize == '0);
      if (scanStart) begin
        issuing   <= (scanSize != '0);
        scanIndex <= '0;
        count     <= '0;
      end else begin
        if (issuing) begin
          scanIndex <= scanIndex + 1'b1;
          if (scanIndex == lastIndex) begin
            issuing <= 1'b0;
          end
        end
        if (dataValid) begin
          count <= nextCount;
        end
      end
    end
  end

  // Last compare folds straight into the result
  assign scanDone   = emptyDone || (dataValid && lastData);
  assign scanResult = nextCount;

endmodule

/* arrayStore.sv */
//--------------------
// Array store
// Element memory and size table, command port plus a scan read port
//--------------------
`timescale 1ns/1ps
`include "heap_settings.svh"

module arrayStore (
  input  logic           clock,
  input  logic           resetN,
  input  logic           elemWrite,
  input  logic           sizeWrite,
  input  heapPkg::arrayT cmdArray,
  input  heapPkg::indexT cmdIndex,
  input  heapPkg::dataT  cmdData,
  input  heapPkg::sizeT  cmdSize,
  output heapPkg::dataT  cmdReadData,
  output heapPkg::sizeT  cmdReadSize,
  input  heapPkg::arrayT scanArray,
  input  heapPkg::indexT scanIndex,
  output heapPkg::dataT  scanData
);

  localparam int Arrays = `HEAP_ARRAYS;
  localparam int Words  = `HEAP_ARRAYS * `HEAP_ARRAY_LENGTH;
  localparam int AddrBits = `HEAP_ARRAY_BITS + `HEAP_INDEX_BITS;

  heapPkg::dataT       memory [Words];                        // Arrays in fixed blocks
  heapPkg::sizeT       sizes [Arrays];                        // Current size per array
  logic [AddrBits-1:0] cmdAddr;
  logic [AddrBits-1:0] scanAddr;

  assign cmdAddr  = {cmdArray, cmdIndex};
  assign scanAddr = {scanArray, scanIndex};

  //--------------------
  // Element memory
  always_ff @(posedge clock) begin
    if (elemWrite) begin
      memory[cmdAddr] <= cmdData;
    end
    cmdReadData <= memory[cmdAddr];                           // Old data on a same-cycle write
    scanData    <= memory[scanAddr];
  end

  //--------------------
  // Size table
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < Arrays; i++) begin
        sizes[i] <= '0;                                       // All arrays start empty
      end
    end else if (sizeWrite) begin
      sizes[cmdArray] <= cmdSize;
    end
  end

  always_ff @(posedge clock) begin
    cmdReadSize <= sizes[cmdArray];
  end

endmodule

/* arrayAllocator.sv */
//--------------------
// Array allocator
// Free stack of returned arrays, next-new counter and allocation flags
//--------------------
`timescale 1ns/1ps
`include "heap_settings.svh"

module arrayAllocator (
  input  logic           clock,
  input  logic           resetN,
  input  logic           allocStart,
  output logic           allocOk,
  output heapPkg::arrayT allocArray,
  input  logic           freeStart,
  input  heapPkg::arrayT freeArray,
  input  heapPkg::arrayT queryArray,
  output logic           isAllocated,
  output logic           wasFreed
);

  localparam int Arrays = `HEAP_ARRAYS;

  heapPkg::arrayT              freeStack [Arrays];           // Freed array numbers, LIFO
  logic [`HEAP_ARRAY_BITS:0]   freeTop;                      // Entries on the free stack
  logic [`HEAP_ARRAY_BITS:0]   nextNew;                      // Next never-used array
  logic [Arrays-1:0]           allocated;                    // One flag per array
  heapPkg::arrayT              popSlot;
  heapPkg::arrayT              pushSlot;

  assign popSlot  = heapPkg::arrayT'(freeTop - 1'b1);         // Top entry
  assign pushSlot = heapPkg::arrayT'(freeTop);                // First empty entry

  //--------------------
  // Allocation state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freeTop    <= '0;
      nextNew    <= '0;
      allocated  <= '0;
      allocOk    <= 1'b0;
      allocArray <= '0;
    end else if (allocStart) begin
      if (freeTop != '0) begin                                // Reuse last freed first
        allocOk             <= 1'b1;
        allocArray          <= freeStack[popSlot];
        allocated[freeStack[popSlot]] <= 1'b1;
        freeTop             <= freeTop - 1'b1;
      end else if (nextNew < Arrays) begin                    // Fresh array
        allocOk             <= 1'b1;
        allocArray          <= heapPkg::arrayT'(nextNew);
        allocated[heapPkg::arrayT'(nextNew)] <= 1'b1;
        nextNew             <= nextNew + 1'b1;
      end else begin
        allocOk <= 1'b0;                                      // Pool exhausted
      end
    end else if (freeStart) begin
      allocated[freeArray] <= 1'b0;                           // Clear the freed array itself
      freeTop              <= freeTop + 1'b1;
    end
  end

  // Stack contents
  always_ff @(posedge clock) begin
    if (freeStart && !allocStart) begin
      freeStack[pushSlot] <= freeArray;
    end
  end

  //--------------------
  // Lookup for the controller
  assign isAllocated = allocated[queryArray];
  assign wasFreed    = !allocated[queryArray] && ({1'b0, queryArray} < nextNew);

endmodule

/* heapPkg.sv */
//--------------------
// Array heap types
// Field widths, command opcodes, error codes and search kinds
//--------------------
`include "heap_settings.svh"

package heapPkg;

  //--------------------
  // Command fields
  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayT;                // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;                // Element index
  typedef logic [`HEAP_INDEX_BITS:0] sizeT;                   // 0 up to full length
  typedef logic [`HEAP_DATA_BITS-1:0] dataT;                  // Element value

  //--------------------
  // Host commands
  typedef enum logic [3:0] {
    opAlloc,                                                  // Hand out an array
    opFree,                                                   // Return an array to the pool
    opWrite,                                                  // Write, extends the size
    opRead,
    opSize,
    opPush,
    opPop,
    opIndex,                                                  // Last equal position plus one
    opLess,                                                   // Count of smaller elements
    opGreater                                                 // Count of larger elements
  } opT;

  // Per command status
  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                          // Never handed out
    errFreed,                                                 // Handed out once, now free
    errBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } errorT;

  // Comparison used by the scan
  typedef enum logic [1:0] {
    scanIndex,
    scanLess,
    scanGreater
  } scanT;

endpackage

/* heap_settings.svh */
//--------------------
// Array heap sizes
// Widths of array numbers, indices and elements, and the pool dimensions
//--------------------
`ifndef HEAP_SETTINGS_SVH
`define HEAP_SETTINGS_SVH

//--------------------
// Base widths
`define HEAP_ARRAY_BITS 2                                     // Bits in an array number
`define HEAP_INDEX_BITS 3                                     // Bits in an element index
`define HEAP_DATA_BITS 12                                     // Element width

//--------------------
// Derived pool sizes
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)                   // Arrays in the pool
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)             // Elements per array

`endif
